/* hdl/adc_tpl_pkg.sv */
/*
  Shared constants for the transport-layer ADC register block.
  Register words are 14-bit addresses with 32-bit data.
  Each channel carries one 16-bit sample per link_clk.
  Channel windows are 16 words each, starting at chan_base.
*/
`default_nettype none

package adc_tpl_pkg;

  // ******************************
  // widths and fixed values
  // ******************************
  localparam int sample_width  = 16;
  localparam int up_addr_width = 14;
  localparam int up_data_width = 32;

  localparam logic [up_data_width-1:0] core_version   = 32'h0001_0061;
  localparam logic [up_data_width-1:0] unmapped_rdata = 32'hdead_dead;

  // cycles until an unclaimed request is acked by the regmap
  localparam int ack_timeout   = 8;
  // consecutive samples needed to enter or leave out-of-sync
  localparam int oos_threshold = 8;

  // ******************************
  // common registers
  // ******************************
  localparam logic [up_addr_width-1:0] reg_version   = 14'h000;
  localparam logic [up_addr_width-1:0] reg_id        = 14'h001;
  localparam logic [up_addr_width-1:0] reg_scratch   = 14'h002;
  localparam logic [up_addr_width-1:0] reg_ctrl      = 14'h010;
  localparam logic [up_addr_width-1:0] reg_clk_ratio = 14'h015;
  localparam logic [up_addr_width-1:0] reg_status    = 14'h017;
  localparam logic [up_addr_width-1:0] reg_ovf       = 14'h020;

  localparam int ctrl_run_bit       = 0;
  localparam int status_running_bit = 0;
  localparam int status_oos_bit     = 1;
  localparam int status_pn_err_bit  = 2;
  localparam int ovf_bit            = 0;

  // ******************************
  // channel registers
  // ******************************
  localparam int chan_base   = 'h100;
  localparam int chan_stride = 'h10;

  localparam logic [3:0] reg_chan_ctrl   = 4'h0;
  localparam logic [3:0] reg_chan_status = 4'h1;
  localparam logic [3:0] reg_chan_pn_sel = 4'h9;

  localparam int chan_enable_bit   = 0;
  localparam int chan_fmt_type_bit = 4;
  localparam int chan_sign_ext_bit = 5;
  localparam int chan_fmt_en_bit   = 6;
  localparam int chan_oos_bit      = 1;
  localparam int chan_pn_err_bit   = 2;

  // values 2 to 15 are reserved, the monitor idles on them
  typedef enum logic [3:0] {
    pn_sel_pn16 = 4'd0,
    pn_sel_ramp = 4'd1
  } pn_sel_e;

  typedef enum logic {
    bus_idle,
    bus_wait
  } bus_state_e;

endpackage

`default_nettype wire

/* hdl/adc_tpl_regmap.sv */
/*
  Bus output stage of the register map.
  Only one request may be outstanding at a time.
  Requests no block claims are acked after ack_timeout cycles.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_tpl_regmap
  import adc_tpl_pkg::*;
#(
  parameter int num_channels = 2
) (
  input  logic                                     link_clk,
  input  logic                                     adc_rst,
  input  logic                                     up_wreq,
  input  logic                                     up_rreq,
  input  logic [num_channels:0]                    blk_wack,
  input  logic [num_channels:0]                    blk_rack,
  input  logic [(num_channels+1)*up_data_width-1:0] blk_rdata,
  input  logic [num_channels-1:0]                  chan_pn_err,
  input  logic [num_channels-1:0]                  chan_pn_oos,
  output logic                                     up_wack,
  output logic                                     up_rack,
  output logic [up_data_width-1:0]                 up_rdata,
  output logic                                     any_pn_err,
  output logic                                     any_pn_oos
);

  localparam int cnt_width = $clog2(ack_timeout) + 1;

  bus_state_e               state;
  logic [cnt_width-1:0]     wait_cnt;
  logic                     rd_pending;
  logic                     blk_ack;
  logic                     timeout;
  logic [up_data_width-1:0] rdata_or;

  // read data of idle blocks is zero, so a plain OR merges them
  always_comb begin
    rdata_or = '0;
    for (int n = 0; n <= num_channels; n++) begin
      rdata_or = rdata_or | blk_rdata[n*up_data_width +: up_data_width];
    end
  end

  assign blk_ack = (|blk_wack) | (|blk_rack);
  assign timeout = (state == bus_wait) && !blk_ack &&
                   (wait_cnt == cnt_width'(ack_timeout - 1));

  // ******************************
  // request tracking
  // ******************************
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      state      <= bus_idle;
      wait_cnt   <= '0;
      rd_pending <= 1'b0;
    end else begin
      case (state)
        bus_idle: begin
          if (up_wreq || up_rreq) begin
            state      <= bus_wait;
            wait_cnt   <= cnt_width'(1);
            rd_pending <= up_rreq;
          end
        end
        bus_wait: begin
          if (blk_ack || timeout) begin
            state <= bus_idle;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: state <= bus_idle;
      endcase
    end
  end

  // output stage, one cycle behind the blocks
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack    <= 1'b0;
      up_rack    <= 1'b0;
      up_rdata   <= '0;
      any_pn_err <= 1'b0;
      any_pn_oos <= 1'b0;
    end else begin
      up_wack    <= (|blk_wack) | (timeout & !rd_pending);
      up_rack    <= (|blk_rack) | (timeout & rd_pending);
      up_rdata   <= (timeout && rd_pending) ? unmapped_rdata : rdata_or;
      any_pn_err <= |chan_pn_err;
      any_pn_oos <= |chan_pn_oos;
    end
  end

endmodule

`default_nettype wire

/* hdl/adc_common_regs.sv */
/*
  Core-wide registers, words 0x000 to 0x0ff.
  Acks and read data come one cycle after the request.
  Unused words in the range ack and read zero.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_common_regs
  import adc_tpl_pkg::*;
#(
  parameter logic [up_data_width-1:0] core_id = '0
) (
  input  logic                     link_clk,
  input  logic                     adc_rst,
  input  logic                     up_wreq,
  input  logic [up_addr_width-1:0] up_waddr,
  input  logic [up_data_width-1:0] up_wdata,
  input  logic                     up_rreq,
  input  logic [up_addr_width-1:0] up_raddr,
  input  logic                     adc_dovf,
  input  logic                     any_pn_err,
  input  logic                     any_pn_oos,
  output logic                     up_wack,
  output logic                     up_rack,
  output logic [up_data_width-1:0] up_rdata,
  output logic                     run
);

  localparam logic [up_data_width-1:0] clk_ratio = 32'd1;

  logic                     wsel;
  logic                     rsel;
  logic                     ovf_sticky;
  logic [up_data_width-1:0] scratch;
  logic [up_data_width-1:0] rdata_mux;

  // the common range is the first 256 words
  assign wsel = up_wreq && (up_waddr[up_addr_width-1:8] == '0);
  assign rsel = up_rreq && (up_raddr[up_addr_width-1:8] == '0);

  always_comb begin
    rdata_mux = '0;
    case (up_raddr)
      reg_version:   rdata_mux = core_version;
      reg_id:        rdata_mux = core_id;
      reg_scratch:   rdata_mux = scratch;
      reg_ctrl:      rdata_mux[ctrl_run_bit] = run;
      reg_clk_ratio: rdata_mux = clk_ratio;
      reg_status: begin
        rdata_mux[status_running_bit] = run;
        // out-of-sync only means something while the monitors run
        rdata_mux[status_oos_bit]     = any_pn_oos & run;
        rdata_mux[status_pn_err_bit]  = any_pn_err;
      end
      reg_ovf:       rdata_mux[ovf_bit] = ovf_sticky;
      default:       rdata_mux = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack    <= 1'b0;
      up_rack    <= 1'b0;
      up_rdata   <= '0;
      scratch    <= '0;
      run        <= 1'b0;
      ovf_sticky <= 1'b0;
    end else begin
      up_wack  <= wsel;
      up_rack  <= rsel;
      up_rdata <= rsel ? rdata_mux : '0;
      if (wsel && (up_waddr == reg_scratch)) begin
        scratch <= up_wdata;
      end
      if (wsel && (up_waddr == reg_ctrl)) begin
        run <= up_wdata[ctrl_run_bit];
      end
      // a new overflow wins over a clear in the same cycle
      if (adc_dovf) begin
        ovf_sticky <= 1'b1;
      end else if (wsel && (up_waddr == reg_ovf) && up_wdata[ovf_bit]) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/adc_channel_regs.sv */
/*
  Per-channel registers in a 16-word window at
  chan_base + channel_id * chan_stride.
  Acks and read data come one cycle after the request.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_channel_regs
  import adc_tpl_pkg::*;
#(
  parameter int channel_id = 0
) (
  input  logic                     link_clk,
  input  logic                     adc_rst,
  input  logic                     up_wreq,
  input  logic [up_addr_width-1:0] up_waddr,
  input  logic [up_data_width-1:0] up_wdata,
  input  logic                     up_rreq,
  input  logic [up_addr_width-1:0] up_raddr,
  input  logic                     pn_err,
  input  logic                     pn_oos,
  output logic                     up_wack,
  output logic                     up_rack,
  output logic [up_data_width-1:0] up_rdata,
  output logic                     enable,
  output logic                     dfmt_enable,
  output logic                     dfmt_type,
  output logic                     dfmt_sign_extend,
  output pn_sel_e                  pn_sel,
  output logic                     pn_err_sticky
);

  localparam logic [up_addr_width-1:0] win_base =
    up_addr_width'(chan_base + channel_id * chan_stride);

  logic                     wsel;
  logic                     rsel;
  logic [up_data_width-1:0] rdata_mux;

  // window match on the upper address bits
  assign wsel = up_wreq && (up_waddr[up_addr_width-1:4] == win_base[up_addr_width-1:4]);
  assign rsel = up_rreq && (up_raddr[up_addr_width-1:4] == win_base[up_addr_width-1:4]);

  always_comb begin
    rdata_mux = '0;
    case (up_raddr[3:0])
      reg_chan_ctrl: begin
        rdata_mux[chan_enable_bit]   = enable;
        rdata_mux[chan_fmt_type_bit] = dfmt_type;
        rdata_mux[chan_sign_ext_bit] = dfmt_sign_extend;
        rdata_mux[chan_fmt_en_bit]   = dfmt_enable;
      end
      reg_chan_status: begin
        rdata_mux[chan_oos_bit]    = pn_oos;
        rdata_mux[chan_pn_err_bit] = pn_err_sticky;
      end
      reg_chan_pn_sel: rdata_mux[3:0] = pn_sel;
      default:         rdata_mux = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack          <= 1'b0;
      up_rack          <= 1'b0;
      up_rdata         <= '0;
      enable           <= 1'b0;
      dfmt_enable      <= 1'b0;
      dfmt_type        <= 1'b0;
      dfmt_sign_extend <= 1'b0;
      pn_sel           <= pn_sel_pn16;
      pn_err_sticky    <= 1'b0;
    end else begin
      up_wack  <= wsel;
      up_rack  <= rsel;
      up_rdata <= rsel ? rdata_mux : '0;
      if (wsel && (up_waddr[3:0] == reg_chan_ctrl)) begin
        enable           <= up_wdata[chan_enable_bit];
        dfmt_type        <= up_wdata[chan_fmt_type_bit];
        dfmt_sign_extend <= up_wdata[chan_sign_ext_bit];
        dfmt_enable      <= up_wdata[chan_fmt_en_bit];
      end
      if (wsel && (up_waddr[3:0] == reg_chan_pn_sel)) begin
        pn_sel <= pn_sel_e'(up_wdata[3:0]);
      end
      // set by an error pulse, which wins over a write-1 clear
      if (pn_err) begin
        pn_err_sticky <= 1'b1;
      end else if (wsel && (up_waddr[3:0] == reg_chan_status) && up_wdata[chan_pn_err_bit]) begin
        pn_err_sticky <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/adc_pn_monitor.sv */
/*
  PN16 or ramp checker for one channel.
  Each sample is predicted from the previous received one,
  so the monitor seeds itself from the data stream.
  Held in reset while run is low. Reserved selects leave it idle.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_pn_monitor
  import adc_tpl_pkg::*;
(
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    run,
  input  logic                    valid,
  input  logic [sample_width-1:0] data,
  input  pn_sel_e                 pn_sel,
  output logic                    pn_err,
  output logic                    pn_oos
);

  localparam int cnt_width = $clog2(oos_threshold) + 1;

  logic [sample_width-1:0] last_data;
  logic [sample_width-1:0] expected;
  logic                    known_sel;
  logic                    seeded;
  logic                    mismatch;
  logic                    disagree;
  logic [cnt_width-1:0]    streak;

  always_comb begin
    known_sel = 1'b1;
    case (pn_sel)
      // x^16 + x^15 + x^13 + x^4 + 1
      pn_sel_pn16: expected = {last_data[sample_width-2:0],
                               last_data[15] ^ last_data[14] ^ last_data[12] ^ last_data[3]};
      pn_sel_ramp: expected = last_data + sample_width'(1);
      default: begin
        expected  = last_data;
        known_sel = 1'b0;
      end
    endcase
  end

  assign mismatch = (data != expected);
  // a sample that argues against the current sync state
  assign disagree = pn_oos ? !mismatch : mismatch;

  always_ff @(posedge link_clk) begin
    if (valid && known_sel) begin
      last_data <= data;
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst || !run) begin
      seeded <= 1'b0;
      streak <= '0;
      pn_err <= 1'b0;
      pn_oos <= 1'b1;
    end else begin
      pn_err <= 1'b0;
      if (valid && known_sel) begin
        seeded <= 1'b1;
        if (seeded) begin
          pn_err <= mismatch && !pn_oos;
          if (!disagree) begin
            streak <= '0;
          end else if (streak == cnt_width'(oos_threshold - 1)) begin
            pn_oos <= !pn_oos;
            streak <= '0;
          end else begin
            streak <= streak + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/adc_data_format.sv */
/*
  Sample formatter for one channel, one register stage.
  converter_resolution must lie between 2 and sample_width.
  out_data is not gated, only out_valid is.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_data_format
  import adc_tpl_pkg::*;
#(
  parameter int converter_resolution = 14
) (
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    run,
  input  logic                    enable,
  input  logic                    dfmt_enable,
  input  logic                    dfmt_type,
  input  logic                    dfmt_sign_extend,
  input  logic                    valid,
  input  logic [sample_width-1:0] data,
  output logic                    out_valid,
  output logic [sample_width-1:0] out_data
);

  logic                    msb;
  logic [sample_width-1:0] fmt;

  // offset binary to two's complement flips the top converter bit
  assign msb = data[converter_resolution-1] ^ dfmt_type;

  always_comb begin
    for (int i = 0; i < sample_width; i++) begin
      if (!dfmt_enable || (i < converter_resolution - 1)) begin
        fmt[i] = data[i];
      end else if (i == converter_resolution - 1) begin
        fmt[i] = msb;
      end else begin
        fmt[i] = dfmt_sign_extend & msb;
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid & enable & run;
    end
  end

  always_ff @(posedge link_clk) begin
    out_data <= fmt;
  end

endmodule

`default_nettype wire

/* hdl/adc_tpl_core.sv */
/*
  Transport-layer ADC register subsystem, single link_clk domain.
  Register bus: one-cycle strobes, one outstanding request.
  Mapped accesses ack after 2 cycles, unmapped after ack_timeout.
  Samples come out 1 cycle after they go in.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_tpl_core
  import adc_tpl_pkg::*;
#(
  parameter int                       num_channels         = 2,
  parameter int                       converter_resolution = 14,
  parameter logic [up_data_width-1:0] core_id              = '0
) (
  input  logic                                 link_clk,
  input  logic                                 adc_rst,
  input  logic                                 up_wreq,
  input  logic [up_addr_width-1:0]             up_waddr,
  input  logic [up_data_width-1:0]             up_wdata,
  output logic                                 up_wack,
  input  logic                                 up_rreq,
  input  logic [up_addr_width-1:0]             up_raddr,
  output logic [up_data_width-1:0]             up_rdata,
  output logic                                 up_rack,
  input  logic                                 adc_valid,
  input  logic [num_channels*sample_width-1:0] adc_data,
  input  logic                                 adc_dovf,
  output logic [num_channels-1:0]              fmt_valid,
  output logic [num_channels*sample_width-1:0] fmt_data
);

  // slot 0 is the common block, slot n+1 is channel n
  logic [num_channels:0]                     blk_wack;
  logic [num_channels:0]                     blk_rack;
  logic [(num_channels+1)*up_data_width-1:0] blk_rdata;
  logic [num_channels-1:0]                   chan_pn_err;
  logic [num_channels-1:0]                   chan_pn_oos;
  logic                                      any_pn_err;
  logic                                      any_pn_oos;
  logic                                      run;

  adc_tpl_regmap #(
    .num_channels (num_channels)
  ) u_regmap (
    .link_clk    (link_clk),
    .adc_rst     (adc_rst),
    .up_wreq     (up_wreq),
    .up_rreq     (up_rreq),
    .blk_wack    (blk_wack),
    .blk_rack    (blk_rack),
    .blk_rdata   (blk_rdata),
    .chan_pn_err (chan_pn_err),
    .chan_pn_oos (chan_pn_oos),
    .up_wack     (up_wack),
    .up_rack     (up_rack),
    .up_rdata    (up_rdata),
    .any_pn_err  (any_pn_err),
    .any_pn_oos  (any_pn_oos)
  );

  adc_common_regs #(
    .core_id (core_id)
  ) u_common_regs (
    .link_clk   (link_clk),
    .adc_rst    (adc_rst),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .adc_dovf   (adc_dovf),
    .any_pn_err (any_pn_err),
    .any_pn_oos (any_pn_oos),
    .up_wack    (blk_wack[0]),
    .up_rack    (blk_rack[0]),
    .up_rdata   (blk_rdata[0 +: up_data_width]),
    .run        (run)
  );

  // ******************************
  // per-channel blocks
  // ******************************
  for (genvar i = 0; i < num_channels; i++) begin : g_chan
    logic    enable;
    logic    dfmt_enable;
    logic    dfmt_type;
    logic    dfmt_sign_extend;
    logic    pn_err;
    pn_sel_e pn_sel;

    adc_channel_regs #(
      .channel_id (i)
    ) u_channel_regs (
      .link_clk         (link_clk),
      .adc_rst          (adc_rst),
      .up_wreq          (up_wreq),
      .up_waddr         (up_waddr),
      .up_wdata         (up_wdata),
      .up_rreq          (up_rreq),
      .up_raddr         (up_raddr),
      .pn_err           (pn_err),
      .pn_oos           (chan_pn_oos[i]),
      .up_wack          (blk_wack[i+1]),
      .up_rack          (blk_rack[i+1]),
      .up_rdata         (blk_rdata[(i+1)*up_data_width +: up_data_width]),
      .enable           (enable),
      .dfmt_enable      (dfmt_enable),
      .dfmt_type        (dfmt_type),
      .dfmt_sign_extend (dfmt_sign_extend),
      .pn_sel           (pn_sel),
      .pn_err_sticky    (chan_pn_err[i])
    );

    adc_pn_monitor u_pn_monitor (
      .link_clk (link_clk),
      .adc_rst  (adc_rst),
      .run      (run),
      .valid    (adc_valid),
      .data     (adc_data[i*sample_width +: sample_width]),
      .pn_sel   (pn_sel),
      .pn_err   (pn_err),
      .pn_oos   (chan_pn_oos[i])
    );

    adc_data_format #(
      .converter_resolution (converter_resolution)
    ) u_data_format (
      .link_clk         (link_clk),
      .adc_rst          (adc_rst),
      .run              (run),
      .enable           (enable),
      .dfmt_enable      (dfmt_enable),
      .dfmt_type        (dfmt_type),
      .dfmt_sign_extend (dfmt_sign_extend),
      .valid            (adc_valid),
      .data             (adc_data[i*sample_width +: sample_width]),
      .out_valid        (fmt_valid[i]),
      .out_data         (fmt_data[i*sample_width +: sample_width])
    );
  end

endmodule

`default_nettype wire

/* tests/adc_tpl_core_tb.sv */
/*
  Trace-driven testbench for the ADC transport-layer register core.
  Records are read from tests/adc_tpl_trace.txt, relative to the project root.
  Assumes 2 channels, 14-bit converter resolution and the package address map.
  Channel 1 always carries a ramp unless it is the target of a G record.
*/
`timescale 1ns/1ns
`default_nettype none

module adc_tpl_core_tb
  import adc_tpl_pkg::*;
();

  localparam int tb_channels = 2;
  localparam int tb_resolution = 14;
  localparam logic [up_data_width-1:0] tb_core_id = 32'h0000_a5c1;

  logic                                link_clk;
  logic                                adc_rst;
  logic                                up_wreq;
  logic [up_addr_width-1:0]            up_waddr;
  logic [up_data_width-1:0]            up_wdata;
  logic                                up_wack;
  logic                                up_rreq;
  logic [up_addr_width-1:0]            up_raddr;
  logic [up_data_width-1:0]            up_rdata;
  logic                                up_rack;
  logic                                adc_valid;
  logic [tb_channels*sample_width-1:0] adc_data;
  logic                                adc_dovf;
  logic [tb_channels-1:0]              fmt_valid;
  logic [tb_channels*sample_width-1:0] fmt_data;

  int                       err_cnt = 0;
  int                       check_cnt = 0;
  int                       limit = 8 + 200;
  integer                   seed;
  logic                     run_sh;
  logic [tb_channels-1:0]   en_sh;
  logic [up_data_width-1:0] ctrl_sh [0:tb_channels-1];
  logic [sample_width-1:0]  chan_last [0:tb_channels-1];

  adc_tpl_core #(
    .num_channels         (tb_channels),
    .converter_resolution (tb_resolution),
    .core_id              (tb_core_id)
  ) u_dut (
    .link_clk  (link_clk),
    .adc_rst   (adc_rst),
    .up_wreq   (up_wreq),
    .up_waddr  (up_waddr),
    .up_wdata  (up_wdata),
    .up_wack   (up_wack),
    .up_rreq   (up_rreq),
    .up_raddr  (up_raddr),
    .up_rdata  (up_rdata),
    .up_rack   (up_rack),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .adc_dovf  (adc_dovf),
    .fmt_valid (fmt_valid),
    .fmt_data  (fmt_data)
  );

  initial begin
    link_clk = 1'b0;
    forever #5 link_clk = ~link_clk;
  end

  // ******************************
  // compare tasks
  // ******************************
  task automatic check_rdata(input string name, input logic [up_data_width-1:0] exp,
                             input logic [up_data_width-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_sample(input string name, input logic [sample_width-1:0] exp,
                              input logic [sample_width-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      $display("ERR %s fmt_valid: expected %b, got %b", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_ack(input string name, input bit got, input int lat, input int exp_lat);
    check_cnt++;
    if (!got) begin
      $display("%s: no ack arrived within %0d cycles of the request", name, lat);
      err_cnt++;
    end else if (lat != exp_lat) begin
      $display("%s: ack arrived %0d cycles after the request, not %0d", name, lat, exp_lat);
      err_cnt++;
    end
  endtask

  task automatic check_all_valid(input string name);
    for (int c = 0; c < tb_channels; c++) begin
      check_valid(name, run_sh & en_sh[c], fmt_valid[c]);
    end
  endtask

  // ******************************
  // reference rules and drivers
  // ******************************
  function automatic logic [sample_width-1:0] pn16_next(input logic [sample_width-1:0] x);
    return {x[14:0], x[15] ^ x[14] ^ x[12] ^ x[3]};
  endfunction

  // reference formatter for the converter resolution of the DUT
  function automatic logic [sample_width-1:0] apply_format(
    input logic [sample_width-1:0]  raw,
    input logic [up_data_width-1:0] ctrl);
    logic [sample_width-1:0] low_mask;
    logic [sample_width-1:0] res;
    logic                    top;
    low_mask = (sample_width'(1) << (tb_resolution - 1)) - 1'b1;
    top      = raw[tb_resolution-1] ^ ctrl[chan_fmt_type_bit];
    res      = raw & low_mask;
    if (top) begin
      res = res | (sample_width'(1) << (tb_resolution - 1));
      if (ctrl[chan_sign_ext_bit]) begin
        res = res | ~((sample_width'(1) << tb_resolution) - 1'b1);
      end
    end
    if (ctrl[chan_fmt_en_bit]) begin
      return res;
    end else begin
      return raw;
    end
  endfunction

  // formatted output of one channel, only while its samples are valid
  task automatic check_chan_data(input string name, input int c,
                                 input logic [sample_width-1:0] raw);
    if (run_sh && en_sh[c]) begin
      check_sample(name, apply_format(raw, ctrl_sh[c]),
                   fmt_data[c*sample_width +: sample_width]);
    end
  endtask

  function automatic bit addr_mapped(input logic [up_addr_width-1:0] addr);
    return (addr < 'h100) || ((addr >= chan_base) &&
           (addr < chan_base + tb_channels * chan_stride));
  endfunction

  // one request, then wait for the ack; value is wdata or the expected read data
  task automatic bus_access(input string name, input bit is_wr,
                            input logic [up_addr_width-1:0] addr,
                            input logic [up_data_width-1:0] value);
    int lat;
    bit got;
    lat = 0;
    got = 1'b0;
    @(posedge link_clk);
    if (is_wr) begin
      up_wreq  <= 1'b1;
      up_waddr <= addr;
      up_wdata <= value;
    end else begin
      up_rreq  <= 1'b1;
      up_raddr <= addr;
    end
    @(posedge link_clk);
    up_wreq <= 1'b0;
    up_rreq <= 1'b0;
    while (!got && lat < ack_timeout + 4) begin
      @(negedge link_clk);
      lat++;
      got = is_wr ? up_wack : up_rack;
    end
    check_ack(name, got, lat, addr_mapped(addr) ? 2 : ack_timeout);
    if (!is_wr && got) begin
      check_rdata(name, value, up_rdata);
    end
    if (is_wr && addr == reg_ctrl) begin
      run_sh = value[ctrl_run_bit];
    end
    for (int c = 0; c < tb_channels; c++) begin
      if (is_wr && addr == chan_base + c * chan_stride + reg_chan_ctrl) begin
        en_sh[c]   = value[chan_enable_bit];
        ctrl_sh[c] = value;
      end
    end
  endtask

  // corrupt is -1 for none, -2 for every sample, else one flipped sample index
  task automatic gen_run(input string name, input int chan, input string kind,
                         input int count, input int corrupt);
    logic [sample_width-1:0] val [0:tb_channels-1];
    logic [sample_width-1:0] prev [0:tb_channels-1];
    for (int i = 0; i < count; i++) begin
      for (int c = 0; c < tb_channels; c++) begin
        if (c == chan && kind == "pn16") begin
          chan_last[c] = pn16_next(chan_last[c]);
        end else begin
          chan_last[c] = chan_last[c] + 1'b1;
        end
        val[c] = chan_last[c];
      end
      if (corrupt == -2 || corrupt == i) begin
        val[chan] = ~val[chan];
      end
      @(posedge link_clk);
      adc_valid <= 1'b1;
      adc_data  <= {val[1], val[0]};
      @(negedge link_clk);
      if (i > 0) begin
        check_all_valid(name);
      end
      for (int c = 0; c < tb_channels; c++) begin
        if (i > 0) begin
          check_chan_data(name, c, prev[c]);
        end
        prev[c] = val[c];
      end
    end
    @(posedge link_clk);
    adc_valid <= 1'b0;
    @(negedge link_clk);
    check_all_valid(name);
    for (int c = 0; c < tb_channels; c++) begin
      check_chan_data(name, c, prev[c]);
    end
  endtask

  // channel 0 gets the raw sample, channel 1 keeps its ramp going
  task automatic format_check(input string name, input logic [sample_width-1:0] raw,
                              input logic [sample_width-1:0] exp);
    chan_last[0] = raw;
    chan_last[1] = chan_last[1] + 1'b1;
    @(posedge link_clk);
    adc_valid <= 1'b1;
    adc_data  <= {chan_last[1], raw};
    @(posedge link_clk);
    adc_valid <= 1'b0;
    @(negedge link_clk);
    check_sample(name, exp, fmt_data[sample_width-1:0]);
    check_chan_data(name, 1, chan_last[1]);
    check_all_valid(name);
  endtask

  // ******************************
  // watchdog
  // ******************************
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= limit) begin
      @(posedge link_clk);
      cycles++;
    end
    $display("watchdog: the run did not finish within %0d cycles", limit);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    int                       fd;
    int                       code;
    int                       chan;
    int                       count;
    int                       corrupt;
    string                    kind;
    string                    name;
    string                    tok;
    string                    line;
    logic [up_addr_width-1:0] addr;
    logic [up_data_width-1:0] data;
    seed      = 81;
    adc_rst   = 1'b1;
    up_wreq   = 1'b0;
    up_waddr  = '0;
    up_wdata  = '0;
    up_rreq   = 1'b0;
    up_raddr  = '0;
    adc_valid = 1'b0;
    adc_data  = '0;
    adc_dovf  = 1'b0;
    run_sh    = 1'b0;
    en_sh     = '0;
    for (int c = 0; c < tb_channels; c++) begin
      chan_last[c] = $random(seed);
      ctrl_sh[c]   = '0;
    end
    repeat (8) @(posedge link_clk);
    adc_rst <= 1'b0;

    fd = $fopen("tests/adc_tpl_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tests/adc_tpl_trace.txt");
      err_cnt++;
    end else begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind == "#") begin
          code = $fgets(line, fd);
        end else begin
          code = $fscanf(fd, "%s", name);
          limit = limit + 200;
          case (kind)
            "W": begin
              code = $fscanf(fd, "%h %h", addr, data);
              bus_access(name, 1'b1, addr, data);
            end
            "R": begin
              code = $fscanf(fd, "%h %h", addr, data);
              bus_access(name, 1'b0, addr, data);
            end
            "G": begin
              code = $fscanf(fd, "%d %s %d %s", chan, line, count, tok);
              limit = limit + count;
              if (tok == "none") begin
                corrupt = -1;
              end else if (tok == "all") begin
                corrupt = -2;
              end else begin
                code = $sscanf(tok, "%d", corrupt);
              end
              gen_run(name, chan, line, count, corrupt);
            end
            "D": begin
              code = $fscanf(fd, "%h %h", addr, data);
              format_check(name, data[31:16], data[15:0]);
            end
            "O": begin
              @(posedge link_clk);
              adc_dovf <= 1'b1;
              @(posedge link_clk);
              adc_dovf <= 1'b0;
            end
            default: begin
              $display("unknown record kind %s in the trace", kind);
              err_cnt++;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tests/adc_tpl_trace.txt */
# kind name, then hex fields: W addr data | R addr expected | D 0 rawexpected | O
# G chan kind count corrupt (decimal), corrupt is a sample index, none or all
R ver_rd 0000 00010061
R id_rd 0001 0000a5c1
W scratch_wr 0002 5a5a1234
R scratch_rd 0002 5a5a1234
R unmapped_rd 0200 deaddead
R status_reset 0017 00000000
G idle_no_valid 0 ramp 4 none
W ch0_enable 0100 00000001
W ch1_enable 0110 00000001
W ch1_sel_ramp 0119 00000001
W run_on 0010 00000001
R status_run 0017 00000003
D fmt_pass 0 9abc9abc
W ch0_fmt_sext 0100 00000071
D fmt_sext 0 1234f234
W ch0_fmt_zero 0100 00000041
D fmt_zero 0 eabc2abc
W ch0_off 0100 00000000
D fmt_off 0 55555555
W ch0_on 0100 00000001
G pn16_clean 0 pn16 20 none
R ch0_stat_pn16 0101 00000000
R status_sync 0017 00000001
W ch0_sel_ramp 0109 00000001
G ramp_clean 0 ramp 12 none
R ch0_stat_ramp 0101 00000000
G ramp_corrupt 0 ramp 12 5
R ch0_stat_err 0101 00000004
R status_err 0017 00000005
W ch0_err_clr 0101 00000004
R ch0_stat_clr 0101 00000000
G ramp_lost 0 ramp 12 all
R ch0_stat_oos 0101 00000006
R status_oos 0017 00000007
O ovf_pulse
R ovf_set 0020 00000001
W ovf_clr 0020 00000001
R ovf_cleared 0020 00000000

/* adc_tpl_core.f */
hdl/adc_tpl_pkg.sv
hdl/adc_tpl_regmap.sv
hdl/adc_common_regs.sv
hdl/adc_channel_regs.sv
hdl/adc_pn_monitor.sv
hdl/adc_data_format.sv
hdl/adc_tpl_core.sv
tests/adc_tpl_core_tb.sv
